// ==== Bender.yml ====
package:
  name: hdd_host_bridge

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/hdd_bridge_pkg.sv
      - rtl/hdd_request_latch.sv
      - rtl/hdd_sector_buffer.sv
      - rtl/hdd_host_sequencer.sv
      - rtl/hdd_host_bridge.sv
  - target: test
    include_dirs:
      - rtl
      - tb
    files:
      - tb/hdd_host_bridge_tb.sv

// ==== rtl/hdd_bridge_config.svh ====
`ifndef HDD_BRIDGE_CONFIG_SVH
`define HDD_BRIDGE_CONFIG_SVH

// Two hard-disk units, as the host block service exposes them
`define HDD_UNITS 2

// One sector is 512 bytes, so the buffer needs 9 address bits
`define HDD_BUFF_AW 9
`define HDD_SECTOR_BYTES 512

// Sector number as the core presents it
`define HDD_SECTOR_W 16

// Block address on the host side
`define HDD_LBA_W 32

// Buffer data is byte wide on both ports
`define HDD_DATA_W 8

`endif

// ==== rtl/hdd_bridge_pkg.sv ====
`include "hdd_bridge_config.svh"

package hdd_bridge_pkg;

	// One request from the core
	// Read and write are single-cycle pulses
	typedef struct packed {
		logic                         read;
		logic                         write;
		logic [$clog2(`HDD_UNITS)-1:0] unit;
		logic [`HDD_SECTOR_W-1:0]     sector;
	} hdd_req_t;

	// Request toward the host block service
	// One read and one write strobe per unit, shared block address
	typedef struct packed {
		logic [`HDD_LBA_W-1:0] lba;
		logic [`HDD_UNITS-1:0] rd;
		logic [`HDD_UNITS-1:0] wr;
	} host_req_t;

	// One access to the sector buffer
	typedef struct packed {
		logic [`HDD_BUFF_AW-1:0] addr;
		logic [`HDD_DATA_W-1:0]  wdata;
		logic                    we;
	} buff_port_t;

	// Image status per unit
	// Protect marks a read-only image
	typedef struct packed {
		logic [`HDD_UNITS-1:0] mounted;
		logic [`HDD_UNITS-1:0] protect;
	} mount_state_t;

endpackage

// ==== rtl/hdd_host_bridge.sv ====
`timescale 1ns/1ps
`include "hdd_bridge_config.svh"

module hdd_host_bridge
	import hdd_bridge_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  hdd_req_t              core_req,
	input  buff_port_t            core_port,
	output byte                   core_rdata,
	output host_req_t             host_req,
	input  logic [`HDD_UNITS-1:0] sd_ack,
	input  buff_port_t            host_port,
	output byte                   host_rdata,
	input  logic [`HDD_UNITS-1:0] img_mounted,
	input  logic                  img_readonly,
	input  logic [63:0]           img_size,
	output logic                  cpu_wait,
	output mount_state_t          mount
);

	// Latched request and its handshake with the sequencer
	hdd_req_t pending_req;
	logic     pending;
	logic     busy;
	logic     done;

	// Acknowledge of the unit in service, gates host buffer writes
	logic     host_ack;

	// Catches core pulses
	hdd_request_latch i_hdd_request_latch (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.core_req    (core_req),
		.busy        (busy),
		.done        (done),
		.pending_req (pending_req),
		.pending     (pending)
	);

	// Sector shared between core and host
	hdd_sector_buffer i_hdd_sector_buffer (
		.clk_sys    (clk_sys),
		.core_port  (core_port),
		.core_rdata (core_rdata),
		.host_port  (host_port),
		.host_ack   (host_ack),
		.host_rdata (host_rdata)
	);

	// Host strobes, wait and mount status
	hdd_host_sequencer i_hdd_host_sequencer (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.pending_req  (pending_req),
		.pending      (pending),
		.sd_ack       (sd_ack),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.host_req     (host_req),
		.host_ack     (host_ack),
		.busy         (busy),
		.done         (done),
		.cpu_wait     (cpu_wait),
		.mount        (mount)
	);

endmodule

// ==== rtl/hdd_host_sequencer.sv ====
`timescale 1ns/1ps
`include "hdd_bridge_config.svh"

module hdd_host_sequencer
	import hdd_bridge_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  hdd_req_t              pending_req,
	input  logic                  pending,
	input  logic [`HDD_UNITS-1:0] sd_ack,
	input  logic [`HDD_UNITS-1:0] img_mounted,
	input  logic                  img_readonly,
	input  logic [63:0]           img_size,
	output host_req_t             host_req,
	output logic                  host_ack,
	output logic                  busy,
	output logic                  done,
	output logic                  cpu_wait,
	output mount_state_t          mount
);

	localparam logic ST_IDLE    = 1'b0;
	localparam logic ST_SERVING = 1'b1;

	logic state;
	logic rd_strobe;
	logic wr_strobe;
	logic ack_d;
	logic ack_rise;
	logic ack_fall;

	// Acknowledge of the unit held in the latch
	// The unit is stable for the whole transfer
	assign host_ack = sd_ack[pending_req.unit];

	// Edges against last cycle's acknowledge
	assign ack_rise = host_ack & ~ack_d;
	assign ack_fall = ~host_ack & ack_d;

	assign busy = (state == ST_SERVING);

	// Done pulse in the same cycle the falling edge is seen
	// Latch drops pending on the same edge that returns us to idle,
	// so the old request is not picked up a second time
	assign done = busy & ack_fall;

	// Sector number zero-extended into the host block address
	assign host_req.lba = `HDD_LBA_W'(pending_req.sector);

	// Steer each strobe to the latched unit only
	assign host_req.rd = `HDD_UNITS'(rd_strobe) << pending_req.unit;
	assign host_req.wr = `HDD_UNITS'(wr_strobe) << pending_req.unit;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state     <= ST_IDLE;
			rd_strobe <= 1'b0;
			wr_strobe <= 1'b0;
			cpu_wait  <= 1'b0;
			ack_d     <= 1'b0;
		end else begin
			ack_d <= host_ack;
			if (state == ST_IDLE) begin
				// Start service as soon as a request is latched
				// Strobe and wait both rise on this edge
				if (pending) begin
					state     <= ST_SERVING;
					rd_strobe <= pending_req.read;
					// Read wins if both pulses came together
					wr_strobe <= pending_req.write & ~pending_req.read;
					cpu_wait  <= 1'b1;
				end
			end else begin
				if (ack_rise) begin
					// Host has taken the request
					rd_strobe <= 1'b0;
					wr_strobe <= 1'b0;
				end else if (ack_fall) begin
					// Transfer finished, release the core
					state    <= ST_IDLE;
					cpu_wait <= 1'b0;
				end
			end
		end
	end

	// Mount status per unit
	// Set from the image size and read-only flag on the mount pulse
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mount <= '0;
		end else begin
			for (int u = 0; u < `HDD_UNITS; u++) begin
				if (img_mounted[u]) begin
					// Empty image means the unit is unmounted
					mount.mounted[u] <= (img_size != 64'd0);
					mount.protect[u] <= img_readonly;
				end
			end
		end
	end

endmodule

// ==== rtl/hdd_request_latch.sv ====
`timescale 1ns/1ps

module hdd_request_latch
	import hdd_bridge_pkg::*;
(
	input  logic     clk_sys,
	input  logic     reset,
	input  hdd_req_t core_req,
	input  logic     busy,
	input  logic     done,
	output hdd_req_t pending_req,
	output logic     pending
);

	logic req_pulse;
	logic accept;

	// Either operation pulse counts as a request
	assign req_pulse = core_req.read | core_req.write;

	// Only take a new request when nothing is queued or in service
	// Pulses that arrive while the core should be waiting are dropped
	assign accept = req_pulse & ~pending & ~busy;

	// Pending level
	// Rises one cycle after the pulse, drops on the done pulse
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pending <= 1'b0;
		end else if (done) begin
			pending <= 1'b0;
		end else if (accept) begin
			pending <= 1'b1;
		end
	end

	// Operation, unit and sector of the accepted request
	// Held until the next accepted pulse, so a dropped pulse leaves them alone
	// Cleared on reset so the strobe steering starts from a known unit
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pending_req <= '0;
		end else if (accept) begin
			pending_req <= core_req;
		end
	end

endmodule

// ==== rtl/hdd_sector_buffer.sv ====
`timescale 1ns/1ps
`include "hdd_bridge_config.svh"

module hdd_sector_buffer
	import hdd_bridge_pkg::*;
(
	input  logic       clk_sys,
	input  buff_port_t core_port,
	output byte        core_rdata,
	input  buff_port_t host_port,
	input  logic       host_ack,
	output byte        host_rdata
);

	// One sector of storage, shared by core and host
	logic [`HDD_DATA_W-1:0] mem [`HDD_SECTOR_BYTES];

	logic host_we;

	// Host writes count only during the acknowledge of the unit in service
	// Stray host bus writes for other units never reach this sector
	assign host_we = host_port.we & host_ack;

	// Core port
	// Write is unconditional, read data comes one cycle after the address
	always @(posedge clk_sys) begin
		if (core_port.we) begin
			mem[core_port.addr] <= core_port.wdata;
		end
		core_rdata <= mem[core_port.addr];
	end

	// Host port
	// Same registered read, so host sees a byte one cycle after its address
	always @(posedge clk_sys) begin
		if (host_we) begin
			mem[host_port.addr] <= host_port.wdata;
		end
		host_rdata <= mem[host_port.addr];
	end

endmodule

// ==== sim.f ====
+incdir+rtl
+incdir+tb
rtl/hdd_bridge_pkg.sv
rtl/hdd_request_latch.sv
rtl/hdd_sector_buffer.sv
rtl/hdd_host_sequencer.sv
rtl/hdd_host_bridge.sv
tb/hdd_host_bridge_tb.sv

// ==== tb/hdd_bridge_vectors.svh ====
`ifndef HDD_BRIDGE_VECTORS_SVH
`define HDD_BRIDGE_VECTORS_SVH

// Columns: operation, unit, sector, image size, read-only flag, expected bits
// Mount row expects the whole mount state {mounted, protect}
// Read and write rows expect the host strobes {rd, wr}
task automatic load_vectors();
	// Read-only image on unit 0, unit 1 stays empty
	vectors[0] = '{OP_MOUNT, 1'b0, 16'h0000, 64'h0000_0000_0010_0000, 1'b1, 4'b0101};
	// Writable image on unit 1
	vectors[1] = '{OP_MOUNT, 1'b1, 16'h0000, 64'h0000_0000_0020_0000, 1'b0, 4'b1101};
	vectors[2] = '{OP_READ, 1'b1, 16'h1234, 64'h0, 1'b0, 4'b1000};
	vectors[3] = '{OP_WRITE, 1'b0, 16'h00a5, 64'h0, 1'b0, 4'b0001};
	// Top of the sector range
	vectors[4] = '{OP_READ, 1'b0, 16'hfffe, 64'h0, 1'b0, 4'b0100};
	vectors[5] = '{OP_WRITE, 1'b1, 16'h0007, 64'h0, 1'b0, 4'b0010};
	// Empty image unmounts unit 0 and clears its protect bit
	vectors[6] = '{OP_MOUNT, 1'b0, 16'h0000, 64'h0, 1'b0, 4'b1000};
endtask

`endif

// ==== tb/hdd_host_bridge_tb.sv ====
`timescale 1ns/1ps
`include "hdd_bridge_config.svh"

module hdd_host_bridge_tb
	import hdd_bridge_pkg::*;
();

	localparam int          NUM_VECTORS = 7;
	localparam logic [31:0] SEED        = 32'hcdf0400d;

	typedef enum logic [1:0] {OP_MOUNT, OP_READ, OP_WRITE} op_t;

	// One transaction of the table
	typedef struct packed {
		op_t         op;
		logic        unit;
		logic [15:0] sector;
		logic [63:0] size;
		logic        readonly;
		logic [3:0]  expect_bits;
	} vector_t;

	logic                  clk_sys;
	logic                  reset;
	hdd_req_t              core_req;
	buff_port_t            core_port;
	byte                   core_rdata;
	host_req_t             host_req;
	logic [`HDD_UNITS-1:0] sd_ack;
	buff_port_t            host_port;
	byte                   host_rdata;
	logic [`HDD_UNITS-1:0] img_mounted;
	logic                  img_readonly;
	logic [63:0]           img_size;
	logic                  cpu_wait;
	mount_state_t          mount;

	vector_t    vectors [NUM_VECTORS];
	// Bytes that the buffer should hold after the last transfer
	logic [7:0] sector_data [`HDD_SECTOR_BYTES];
	int         errors;
	int         timeouts;

	`include "hdd_bridge_vectors.svh"

	hdd_host_bridge i_hdd_host_bridge (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	task automatic log_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		errors++;
		$display("Error: %s got 0x%0h expected 0x%0h", name, got, expected);
	endtask

	task automatic count_failure(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	// Image size and read-only flag ride along with the one-cycle mount pulse
	task automatic apply_mount(input vector_t v);
		@(posedge clk_sys);
		img_mounted[v.unit] <= 1'b1;
		img_size            <= v.size;
		img_readonly        <= v.readonly;
		@(posedge clk_sys);
		img_mounted <= '0;
		@(negedge clk_sys);
		if (mount !== v.expect_bits) log_mismatch("mount", mount, v.expect_bits);
	endtask

	// Core loads a fresh sector before a write
	task automatic fill_from_core();
		for (int i = 0; i < `HDD_SECTOR_BYTES; i++) begin
			sector_data[i] = 8'($urandom);
			@(posedge clk_sys);
			core_port <= '{addr: `HDD_BUFF_AW'(i), wdata: sector_data[i], we: 1'b1};
		end
		@(posedge clk_sys);
		core_port <= '0;
	endtask

	// Registered read, so data is sampled one edge after the address
	task automatic core_readback();
		for (int i = 0; i < `HDD_SECTOR_BYTES; i++) begin
			@(posedge clk_sys);
			core_port <= '{addr: `HDD_BUFF_AW'(i), wdata: 8'h00, we: 1'b0};
			@(posedge clk_sys);
			@(negedge clk_sys);
			if (core_rdata !== sector_data[i])
				log_mismatch("core_rdata", $unsigned(core_rdata), sector_data[i]);
		end
		@(posedge clk_sys);
		core_port <= '0;
	endtask

	// Host model
	// Random delay, acknowledge, move the sector, release
	task automatic serve_host(input vector_t v);
		int       delay;
		hdd_req_t stray;
		delay = $urandom_range(6, 1);
		stray = '{read: 1'b1, write: 1'b0, unit: ~v.unit, sector: ~v.sector};
		for (int i = 0; i < delay; i++) begin
			@(posedge clk_sys);
			// Illegal second pulse while the core is held
			if (i == 0) begin
				core_req <= stray;
			end else begin
				core_req <= '0;
			end
		end
		@(posedge clk_sys);
		core_req       <= '0;
		sd_ack[v.unit] <= 1'b1;
		// Strobe drops one cycle after the acknowledge is seen
		@(posedge clk_sys);
		@(negedge clk_sys);
		if (host_req.rd !== 2'b00) log_mismatch("host_req.rd", host_req.rd, 0);
		if (host_req.wr !== 2'b00) log_mismatch("host_req.wr", host_req.wr, 0);
		if (v.op == OP_READ) begin
			for (int i = 0; i < `HDD_SECTOR_BYTES; i++) begin
				sector_data[i] = 8'($urandom);
				@(posedge clk_sys);
				host_port <= '{addr: `HDD_BUFF_AW'(i), wdata: sector_data[i], we: 1'b1};
			end
		end else begin
			for (int i = 0; i < `HDD_SECTOR_BYTES; i++) begin
				@(posedge clk_sys);
				host_port <= '{addr: `HDD_BUFF_AW'(i), wdata: 8'h00, we: 1'b0};
				@(posedge clk_sys);
				@(negedge clk_sys);
				if (host_rdata !== sector_data[i])
					log_mismatch("host_rdata", $unsigned(host_rdata), sector_data[i]);
			end
		end
		@(posedge clk_sys);
		host_port <= '0;
		sd_ack    <= '0;
	endtask

	task automatic run_transfer(input vector_t v);
		int cycles;
		@(posedge clk_sys);
		core_req <= '{read: v.op == OP_READ, write: v.op == OP_WRITE, unit: v.unit,
			sector: v.sector};
		@(posedge clk_sys);
		core_req <= '0;
		// Wait and strobe visible two cycles after the pulse
		@(posedge clk_sys);
		@(negedge clk_sys);
		if (cpu_wait !== 1'b1) log_mismatch("cpu_wait", cpu_wait, 1);
		if ({host_req.rd, host_req.wr} !== v.expect_bits)
			log_mismatch("host_req strobes", {host_req.rd, host_req.wr}, v.expect_bits);
		if (host_req.lba !== 32'(v.sector)) log_mismatch("host_req.lba", host_req.lba, v.sector);
		serve_host(v);
		// Core stays held until the acknowledge drop is seen on the next edge
		@(negedge clk_sys);
		if (cpu_wait !== 1'b1) log_mismatch("cpu_wait", cpu_wait, 1);
		cycles = 0;
		while (cpu_wait !== 1'b0 && cycles < 10) begin
			@(negedge clk_sys);
			cycles++;
		end
		if (cpu_wait !== 1'b0) begin
			timeouts++;
			$display("Timeout: cpu_wait stayed high after the acknowledge ended");
		end
		// The dropped pulse must not start another transfer
		repeat (8) begin
			@(negedge clk_sys);
			if ({host_req.rd, host_req.wr, cpu_wait} !== 5'b0)
				count_failure("A second host request started after the transfer ended");
		end
	endtask

	initial begin
		void'($urandom(SEED));
		errors       = 0;
		timeouts     = 0;
		reset        = 1'b1;
		core_req     = '0;
		core_port    = '0;
		sd_ack       = '0;
		host_port    = '0;
		img_mounted  = '0;
		img_readonly = 1'b0;
		img_size     = '0;
		load_vectors();
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);
		if (cpu_wait !== 1'b0) log_mismatch("cpu_wait", cpu_wait, 0);
		if (mount !== 4'b0000) log_mismatch("mount", mount, 0);
		// Every strobe idle after reset
		if (host_req.rd !== 2'b00) log_mismatch("host_req.rd", host_req.rd, 0);
		if (host_req.wr !== 2'b00) log_mismatch("host_req.wr", host_req.wr, 0);
		for (int r = 0; r < NUM_VECTORS; r++) begin
			case (vectors[r].op)
				OP_MOUNT: apply_mount(vectors[r]);
				OP_READ: begin
					run_transfer(vectors[r]);
					core_readback();
				end
				default: begin
					fill_from_core();
					run_transfer(vectors[r]);
				end
			endcase
		end
		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule
